/* verilog/trap_pkg.sv */
/*
  RISC-V trap vocabulary shared by the checker blocks.
  Only machine-mode synchronous exceptions raised by fetch or decode are
  described. Load/store faults have no code here, and interrupt causes only
  appear through the irq bit of a cause save.
*/
`default_nettype none

package trap_pkg;

  // Program counter and mepc word
  typedef logic [31:0] xlen_t;

  // Exception code as written into mcause, interrupt bit not included
  typedef logic [5:0] exc_code_t;

  ////////////////////
  // Exception codes
  ////////////////////

  // Instruction access fault, raised by the MPU on fetch
  localparam exc_code_t EXC_INSTR_FAULT     = 6'd1;
  localparam exc_code_t EXC_ILLEGAL_INSN    = 6'd2;
  localparam exc_code_t EXC_BREAKPOINT      = 6'd3;
  localparam exc_code_t EXC_ECALL_MMODE     = 6'd11;
  // Instruction bus error, a custom code from the platform range
  localparam exc_code_t EXC_INSTR_BUS_FAULT = 6'd24;

  ////////////////////
  // Stream payloads
  ////////////////////

  // One instruction leaving the write-back stage
  // Several fault flags may be set at once; priority is resolved later
  typedef struct packed {
    logic  valid;
    xlen_t pc;
    logic  illegal;
    logic  ecall;
    logic  ebreak;
    logic  bus_err;
    logic  mpu_err;
  } retire_t;

  // Controller events that stop a retire from trapping this cycle
  typedef struct packed {
    logic irq_ack;
    logic debug_pending;
    logic nmi_trap;
    logic debug_entry;
  } suppress_t;

  // A cause/mepc save issued by the control unit
  typedef struct packed {
    logic      valid;
    logic      irq;
    exc_code_t code;
    xlen_t     mepc;
  } cause_save_t;

  // Expected outcome of one trapping instruction
  typedef struct packed {
    exc_code_t code;
    xlen_t     pc;
  } trap_rec_t;

endpackage

`default_nettype wire

/* verilog/chk_cfg_pkg.sv */
/*
  Sizing of the trap-return checker.
  REC_DEPTH must be a power of two, since the FIFO pointers wrap freely.
  Counters saturate at the top of CNT_W bits.
*/
`default_nettype none

package chk_cfg_pkg;

  // Number of expected trap records held at once
  localparam int unsigned REC_DEPTH    = 4;
  localparam int unsigned REC_PTR_W    = $clog2(REC_DEPTH);
  // Cycles a cause save may wait for its record before it is unexpected
  localparam int unsigned MATCH_WINDOW = 4;
  localparam int unsigned WIN_W        = $clog2(MATCH_WINDOW + 1);
  localparam int unsigned CNT_W        = 8;

  typedef logic [CNT_W-1:0]     cnt_t;
  typedef logic [REC_PTR_W-1:0] rec_ptr_t;
  // Occupancy needs one bit more than a pointer to tell full from empty
  typedef logic [REC_PTR_W:0]   rec_cnt_t;
  typedef logic [WIN_W-1:0]     win_cnt_t;

endpackage

`default_nettype wire

/* verilog/trap_classifier.sv */
/*
  Turns each retiring instruction into at most one expected trap record.
  A record is offered for exactly one cycle and is never held back; when
  the buffer has no room it is lost and overflow_o stays high until reset.
*/
`default_nettype none

module trap_classifier
  import trap_pkg::*;
(
  input  logic      clk,
  input  logic      rst_ni,
  input  retire_t   retire_i,
  input  suppress_t suppress_i,
  output logic      rec_valid_o,
  output trap_rec_t rec_o,
  input  logic      rec_ready_i,
  output logic      overflow_o
);

  logic      suppressed;
  logic      has_exc;
  logic      qualify;
  exc_code_t exc_code;
  logic      rec_valid_q;
  trap_rec_t rec_q;
  logic      overflow_q;

  // Any of these events takes precedence over the exception, so the
  // instruction does not trap and the core saves no exception cause for it
  assign suppressed = suppress_i.irq_ack | suppress_i.debug_pending |
                      suppress_i.nmi_trap | suppress_i.debug_entry;

  assign has_exc = retire_i.mpu_err | retire_i.bus_err | retire_i.illegal |
                   retire_i.ecall | retire_i.ebreak;

  assign qualify = retire_i.valid & has_exc & ~suppressed;

  ////////////////////
  // Cause priority
  ////////////////////

  // Fetch faults first, then decode faults, then the system instructions
  // An MPU fault hides a bus error on the same fetch
  always_comb begin
    if (retire_i.mpu_err) begin
      exc_code = EXC_INSTR_FAULT;
    end else if (retire_i.bus_err) begin
      exc_code = EXC_INSTR_BUS_FAULT;
    end else if (retire_i.illegal) begin
      exc_code = EXC_ILLEGAL_INSN;
    end else if (retire_i.ecall) begin
      exc_code = EXC_ECALL_MMODE;
    end else begin
      exc_code = EXC_BREAKPOINT;
    end
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      rec_valid_q <= 1'b0;
      overflow_q  <= 1'b0;
    end else begin
      rec_valid_q <= qualify;
      // The record offered this cycle finds the buffer full
      if (rec_valid_q && !rec_ready_i) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // Payload follows the valid flag one cycle after the retire
  always_ff @(posedge clk) begin
    if (qualify) begin
      rec_q.code <= exc_code;
      rec_q.pc   <= retire_i.pc;
    end
  end

  assign rec_valid_o = rec_valid_q;
  assign rec_o       = rec_q;
  assign overflow_o  = overflow_q;

endmodule

`default_nettype wire

/* verilog/trap_record_fifo.sv */
/*
  In-order buffer of expected trap records, REC_DEPTH entries deep.
  A push is taken only while ready_o is high; ready_o does not look at a
  pop in the same cycle, so a full buffer refuses a push even then.
  head_o is only meaningful while head_valid_o is high.
*/
`default_nettype none

module trap_record_fifo
  import trap_pkg::*;
  import chk_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_ni,
  input  logic      push_i,
  input  trap_rec_t rec_i,
  output logic      ready_o,
  output logic      head_valid_o,
  output trap_rec_t head_o,
  input  logic      pop_i
);

  trap_rec_t mem_q [REC_DEPTH];
  rec_ptr_t  wr_ptr_q;
  rec_ptr_t  rd_ptr_q;
  rec_cnt_t  count_q;
  logic      do_push;
  logic      do_pop;

  assign ready_o      = (count_q != rec_cnt_t'(REC_DEPTH));
  assign head_valid_o = (count_q != '0);

  // Guard both sides so a stray request cannot corrupt the pointers
  assign do_push = push_i & ready_o;
  assign do_pop  = pop_i & head_valid_o;

  // Oldest record is read straight from storage
  assign head_o = mem_q[rd_ptr_q];

  ////////////////////
  // Pointers
  ////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the occupancy unchanged
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/mepc_matcher.sv */
/*
  Pairs each exception cause save with the oldest expected trap record.
  Saves flagged as interrupts are ignored. Only one save is held at a time;
  another save arriving meanwhile is counted as unexpected and dropped.
  A held save waits at most MATCH_WINDOW cycles for a record.
*/
`default_nettype none

module mepc_matcher
  import trap_pkg::*;
  import chk_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        rst_ni,
  input  cause_save_t save_i,
  input  logic        head_valid_i,
  input  trap_rec_t   head_i,
  output logic        pop_o,
  output cnt_t        match_cnt_o,
  output cnt_t        mismatch_cnt_o,
  output cnt_t        unexpected_cnt_o
);

  typedef enum logic [1:0] {IDLE, WAIT_REC, COMPARE} state_e;

  state_e     state_q;
  state_e     state_d;
  win_cnt_t   win_q;
  win_cnt_t   win_d;
  trap_rec_t  pend_q;
  logic       save_exc;
  logic       accept;
  logic       extra_save;
  logic       no_rec;
  logic       cmp_en;
  logic       cmp_ok;
  logic [1:0] unexp_inc;
  cnt_t       match_q;
  cnt_t       mismatch_q;
  cnt_t       unexpected_q;

  // Add up to three, holding at the top value
  function automatic cnt_t sat_add(cnt_t cnt, logic [1:0] inc);
    logic [CNT_W:0] sum;
    sum = {1'b0, cnt} + {{(CNT_W-1){1'b0}}, inc};
    if (sum[CNT_W]) begin
      return '1;
    end
    return sum[CNT_W-1:0];
  endfunction

  assign save_exc   = save_i.valid & ~save_i.irq;
  assign accept     = save_exc & (state_q == IDLE);
  assign extra_save = save_exc & (state_q != IDLE);

  // Window used up with no record in sight
  assign no_rec = (state_q == WAIT_REC) & ~head_valid_i &
                  (win_q == win_cnt_t'(MATCH_WINDOW - 1));

  assign cmp_en = (state_q == COMPARE) & head_valid_i;
  assign cmp_ok = (pend_q.code == head_i.code) && (pend_q.pc == head_i.pc);
  assign pop_o  = cmp_en;

  assign unexp_inc = {1'b0, no_rec} + {1'b0, extra_save};

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    win_d   = win_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          win_d   = '0;
          state_d = head_valid_i ? COMPARE : WAIT_REC;
        end
      end
      WAIT_REC: begin
        if (head_valid_i) begin
          state_d = COMPARE;
        end else if (no_rec) begin
          state_d = IDLE;
        end else begin
          win_d = win_q + 1'b1;
        end
      end
      COMPARE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      win_q        <= '0;
      match_q      <= '0;
      mismatch_q   <= '0;
      unexpected_q <= '0;
    end else begin
      state_q      <= state_d;
      win_q        <= win_d;
      match_q      <= sat_add(match_q, {1'b0, cmp_en & cmp_ok});
      mismatch_q   <= sat_add(mismatch_q, {1'b0, cmp_en & ~cmp_ok});
      unexpected_q <= sat_add(unexpected_q, unexp_inc);
    end
  end

  // Held save, stored in record form for a direct compare
  always_ff @(posedge clk) begin
    if (accept) begin
      pend_q.code <= save_i.code;
      pend_q.pc   <= save_i.mepc;
    end
  end

  assign match_cnt_o      = match_q;
  assign mismatch_cnt_o   = mismatch_q;
  assign unexpected_cnt_o = unexpected_q;

endmodule

`default_nettype wire

/* verilog/trap_mepc_checker.sv */
/*
  Passive checker of trap entry: each trapping retire must be followed by a
  cause save carrying its exception code and pc as mepc.
  All inputs are single-cycle pulses; the checker never stalls the core.
  Counts settle within MATCH_WINDOW+3 cycles of the later of retire and save.
*/
`default_nettype none

module trap_mepc_checker
  import trap_pkg::*;
  import chk_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        rst_ni,
  input  retire_t     retire_i,
  input  suppress_t   suppress_i,
  input  cause_save_t save_i,
  output logic        overflow_o,
  output cnt_t        match_cnt_o,
  output cnt_t        mismatch_cnt_o,
  output cnt_t        unexpected_cnt_o
);

  // Classifier to buffer
  logic      rec_valid;
  logic      rec_ready;
  trap_rec_t rec;

  // Buffer to matcher
  logic      head_valid;
  trap_rec_t head;
  logic      pop;

  trap_classifier i_trap_classifier (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .retire_i   (retire_i),
    .suppress_i (suppress_i),
    .rec_valid_o(rec_valid),
    .rec_o      (rec),
    .rec_ready_i(rec_ready),
    .overflow_o (overflow_o)
  );

  trap_record_fifo i_trap_record_fifo (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .push_i      (rec_valid),
    .rec_i       (rec),
    .ready_o     (rec_ready),
    .head_valid_o(head_valid),
    .head_o      (head),
    .pop_i       (pop)
  );

  mepc_matcher i_mepc_matcher (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .save_i          (save_i),
    .head_valid_i    (head_valid),
    .head_i          (head),
    .pop_o           (pop),
    .match_cnt_o     (match_cnt_o),
    .mismatch_cnt_o  (mismatch_cnt_o),
    .unexpected_cnt_o(unexpected_cnt_o)
  );

endmodule

`default_nettype wire

/* sim/trap_result_monitor.sv */
/*
  Watches the checker's outputs and compares them at each checkpoint.
  Sampling happens on the falling edge, away from the edge where the DUT
  and the stimulus change. Also flags an overflow flag that falls out of reset.
*/
`default_nettype none

module trap_result_monitor
  import chk_cfg_pkg::*;
(
  input  logic clk,
  input  logic rst_ni,
  input  logic overflow_i,
  input  cnt_t match_cnt_i,
  input  cnt_t mismatch_cnt_i,
  input  cnt_t unexpected_cnt_i,
  input  logic chk_req_i,
  input  cnt_t exp_match_i,
  input  cnt_t exp_mismatch_i,
  input  cnt_t exp_unexpected_i,
  input  logic exp_overflow_i,
  output logic chk_done_o,
  output int   err_cnt_o,
  output int   chk_cnt_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int   err_count  = 0;
  int   chk_count  = 0;
  logic overflow_q = 1'b0;

  task automatic compare_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] got_val);
    if (exp_val !== got_val) begin
      $display("ERR %s exp %0h got %0h", name, exp_val, got_val);
      err_count++;
    end
  endtask

  initial chk_done_o = 1'b0;

  always @(negedge clk) begin
    if (!rst_ni) begin
      chk_done_o <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      if (chk_req_i && !chk_done_o) begin
        compare_value("match_cnt_o", 32'(exp_match_i), 32'(match_cnt_i));
        compare_value("mismatch_cnt_o", 32'(exp_mismatch_i), 32'(mismatch_cnt_i));
        compare_value("unexpected_cnt_o", 32'(exp_unexpected_i), 32'(unexpected_cnt_i));
        compare_value("overflow_o", 32'(exp_overflow_i), 32'(overflow_i));
        chk_count++;
        chk_done_o <= 1'b1;
      end else if (!chk_req_i) begin
        chk_done_o <= 1'b0;
      end
      // Overflow is sticky, so it may only fall through reset
      if (overflow_q && !overflow_i) begin
        $display("Overflow flag dropped while out of reset");
        err_count++;
      end
      overflow_q <= overflow_i;
    end
  end

  assign err_cnt_o = err_count;
  assign chk_cnt_o = chk_count;

endmodule

`default_nettype wire

/* sim/tb_trap_mepc_checker.sv */
/*
  Testbench for the trap-return checker.
  Plays sim/trap_stim.txt, one clock cycle per stimulus line, and hands
  each checkpoint line to the result monitor. Run from the project root.
*/
`default_nettype none

module tb_trap_mepc_checker
  import trap_pkg::*;
  import chk_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Counters settle within MATCH_WINDOW+3 cycles and one more is added as margin
  localparam int    SETTLE_CYCLES = MATCH_WINDOW + 4;
  localparam int    ACK_TIMEOUT   = 10;
  localparam int    MAX_LINES     = 1000;
  localparam string STIM_FILE     = "sim/trap_stim.txt";

  logic        clk;
  logic        rst_ni;
  retire_t     retire;
  suppress_t   suppress;
  cause_save_t save;
  logic        overflow;
  cnt_t        match_cnt;
  cnt_t        mismatch_cnt;
  cnt_t        unexpected_cnt;

  // Checkpoint handshake with the monitor
  logic        chk_req;
  logic        chk_done;
  cnt_t        exp_match;
  cnt_t        exp_mismatch;
  cnt_t        exp_unexpected;
  logic        exp_overflow;
  int          mon_errs;
  int          mon_checks;

  int          fd;
  int          line_no;
  int          file_errs;
  int          timeouts;
  logic        done_reading;
  string       line;

  trap_mepc_checker i_trap_mepc_checker (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .retire_i        (retire),
    .suppress_i      (suppress),
    .save_i          (save),
    .overflow_o      (overflow),
    .match_cnt_o     (match_cnt),
    .mismatch_cnt_o  (mismatch_cnt),
    .unexpected_cnt_o(unexpected_cnt)
  );

  trap_result_monitor i_trap_result_monitor (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .overflow_i      (overflow),
    .match_cnt_i     (match_cnt),
    .mismatch_cnt_i  (mismatch_cnt),
    .unexpected_cnt_i(unexpected_cnt),
    .chk_req_i       (chk_req),
    .exp_match_i     (exp_match),
    .exp_mismatch_i  (exp_mismatch),
    .exp_unexpected_i(exp_unexpected),
    .exp_overflow_i  (exp_overflow),
    .chk_done_o      (chk_done),
    .err_cnt_o       (mon_errs),
    .chk_cnt_o       (mon_checks)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////
  // Line decoding
  ////////////////////

  // Flag column order is mpu, bus, illegal, ecall, ebreak from the top bit
  function automatic retire_t make_retire(input xlen_t pc, input logic [4:0] flags);
    retire_t r;
    r.valid   = 1'b1;
    r.pc      = pc;
    r.mpu_err = flags[4];
    r.bus_err = flags[3];
    r.illegal = flags[2];
    r.ecall   = flags[1];
    r.ebreak  = flags[0];
    return r;
  endfunction

  // A valid cause save built from the irq, code and mepc columns
  function automatic cause_save_t make_save(input logic irq, input exc_code_t code,
                                            input xlen_t mepc);
    cause_save_t c;
    c.valid = 1'b1;
    c.irq   = irq;
    c.code  = code;
    c.mepc  = mepc;
    return c;
  endfunction

  // One cycle of stimulus, applied on the rising edge
  task automatic drive_cycle(input retire_t r, input suppress_t s, input cause_save_t c);
    @(posedge clk);
    retire   <= r;
    suppress <= s;
    save     <= c;
  endtask

  task automatic report_bad_line();
    $display("Malformed stimulus line %0d: %s", line_no, line);
    file_errs++;
  endtask

  task automatic run_checkpoint(input cnt_t m, input cnt_t mm, input cnt_t u, input logic ov);
    int waited;
    drive_cycle('0, '0, '0);
    for (waited = 0; waited < SETTLE_CYCLES; waited++) begin
      @(posedge clk);
    end
    exp_match      <= m;
    exp_mismatch   <= mm;
    exp_unexpected <= u;
    exp_overflow   <= ov;
    chk_req        <= 1'b1;
    // The monitor answers on the falling edge after the request
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!chk_done && waited < ACK_TIMEOUT);
    if (!chk_done) begin
      $display("Timeout: monitor gave no answer for checkpoint at line %0d", line_no);
      timeouts++;
    end
    chk_req <= 1'b0;
  endtask

  task automatic play_line();
    byte         kind;
    string       rest;
    int          n;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    // Blank lines and comment lines take no cycle
    if (line.len() < 1 || line.getc(0) == "#" || line.getc(0) == "\n") begin
      return;
    end
    kind = line.getc(0);
    rest = line.substr(1, line.len() - 1);
    // Suppress column order is irq_ack, debug_pending, nmi_trap, debug_entry from the top bit
    if (kind == "I") begin
      drive_cycle('0, '0, '0);
    end else if (kind == "R") begin
      n = $sscanf(rest, "%h %h %h", f0, f1, f2);
      if (n != 3) report_bad_line();
      else drive_cycle(make_retire(f0, f1[4:0]), suppress_t'(f2[3:0]), '0);
    end else if (kind == "S") begin
      n = $sscanf(rest, "%h %h %h", f0, f1, f2);
      if (n != 3) report_bad_line();
      else drive_cycle('0, '0, make_save(f0[0], exc_code_t'(f1), f2));
    end else if (kind == "B") begin
      n = $sscanf(rest, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
      if (n != 6) report_bad_line();
      else drive_cycle(make_retire(f0, f1[4:0]), suppress_t'(f2[3:0]),
                       make_save(f3[0], exc_code_t'(f4), f5));
    end else if (kind == "C") begin
      n = $sscanf(rest, "%h %h %h %h", f0, f1, f2, f3);
      if (n != 4) report_bad_line();
      else run_checkpoint(cnt_t'(f0), cnt_t'(f1), cnt_t'(f2), f3[0]);
    end else begin
      report_bad_line();
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk            = 1'b0;
    rst_ni         = 1'b0;
    retire         = '0;
    suppress       = '0;
    save           = '0;
    chk_req        = 1'b0;
    exp_match      = '0;
    exp_mismatch   = '0;
    exp_unexpected = '0;
    exp_overflow   = 1'b0;
    line_no        = 0;
    file_errs      = 0;
    timeouts       = 0;
    done_reading   = 1'b0;
    repeat (2) @(posedge clk);
    rst_ni <= 1'b1;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      file_errs++;
    end else begin
      while (!done_reading) begin
        if ($fgets(line, fd) == 0) begin
          done_reading = 1'b1;
        end else begin
          line_no++;
          play_line();
          if (line_no >= MAX_LINES) begin
            $display("Stimulus file has more than %0d lines", MAX_LINES);
            file_errs++;
          end
          done_reading = (timeouts != 0) || (line_no >= MAX_LINES);
        end
      end
      $fclose(fd);
    end
    drive_cycle('0, '0, '0);
    if (mon_checks == 0) begin
      $display("No checkpoint was reached in the stimulus file");
      file_errs++;
    end
    $display("Checkpoints: %0d, value errors: %0d, file errors: %0d, timeouts: %0d",
             mon_checks, mon_errs, file_errs, timeouts);
    if (mon_errs == 0 && file_errs == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/trap_stim.txt */
# Kinds: I idle | R pc flags sup | S irq code mepc | B pc flags sup irq code mepc | C match mismatch unexp ovf
# All hex; flags = mpu bus ill ecall ebreak (top bit first); sup = irq_ack dbg_pending nmi dbg_entry
C 00 00 00 0
R 00000100 0c 0
S 0 18 00000100
C 01 00 00 0
R 00000200 03 0
S 0 02 00000200
C 01 01 00 0
R 00000300 04 0
S 0 02 00000304
C 01 02 00 0
B 00000400 02 0 0 0b 00000400
C 02 02 00 0
B 00000500 19 0 0 01 00000500
C 03 02 00 0
R 00000600 01 0
I
S 0 03 00000600
C 04 02 00 0
R 00000700 04 8
S 0 02 00000700
C 04 02 01 0
R 00000710 02 4
S 0 0b 00000710
C 04 02 02 0
R 00000720 01 2
S 0 03 00000720
C 04 02 03 0
B 00000730 08 1 0 18 00000730
C 04 02 04 0
S 1 0b 00000800
C 04 02 04 0
R 00000a00 04 0
R 00000a04 04 0
R 00000a08 02 0
R 00000a0c 01 0
R 00000a10 04 0
C 04 02 04 1
S 0 02 00000a00
I
S 0 02 00000a04
I
S 0 0b 00000a08
I
S 0 03 00000a0c
C 08 02 04 1

/* verilog.f */
verilog/trap_pkg.sv
verilog/chk_cfg_pkg.sv
verilog/trap_classifier.sv
verilog/trap_record_fifo.sv
verilog/mepc_matcher.sv
verilog/trap_mepc_checker.sv
sim/trap_result_monitor.sv
sim/tb_trap_mepc_checker.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the trap-return checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module tb_trap_mepc_checker -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# The run passes only if the testbench printed its pass line
echo "$out" | grep -qF "Simulation finished: PASS"
